//--- include/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Machine CSR indexes.
`define CSR_MSTATUS    12'h300
`define CSR_MIE        12'h304
`define CSR_MTVEC      12'h305
`define CSR_MEPC       12'h341
`define CSR_MCAUSE     12'h342
`define CSR_MIP        12'h344
`define CSR_MVENDORID  12'hF11
`define CSR_MARCHID    12'hF12
`define CSR_MIMPID     12'hF13
`define CSR_MHARTID    12'hF14

// Read-only ID values.
`define CSR_VENDORID   32'h0000_0A5C
`define CSR_ARCHID     32'h0000_0017
`define CSR_IMPID      32'h0001_0203
`define CSR_HARTID     32'h0000_0000

`define RESET_PC       32'h0000_0200

// mcause codes, one per source.
`define CAUSE_TIMER    32'h8000_0080
`define CAUSE_EXTERNAL 32'h8000_0800
`define CAUSE_SOFTWARE 32'h0000_0800

`endif

//--- verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

	// CSR instruction kind.
	typedef enum logic [1:0] {
		CSR_RW,
		CSR_RS,
		CSR_RC
	} csr_op_e;

	// One CSR instruction.
	typedef struct packed {
		csr_op_e     kind;
		logic [11:0] index;
		logic [31:0] operand;
	} csr_op_t;

	// Interrupt request bits, one per source.
	typedef struct packed {
		logic timer;
		logic external;
		logic software;
	} irq_lines_t;

	// Write port into the CSR file.
	typedef struct packed {
		logic        strobe;
		logic [11:0] index;
		logic [31:0] data;
	} csr_write_t;

	// Trap report.
	typedef struct packed {
		logic        taken;
		logic [31:0] cause;
		logic [31:0] epc;
		logic [31:0] target;
	} trap_t;

endpackage

`default_nettype wire

//--- verilog/irq_sync.sv
`timescale 1ns/100ps
`default_nettype none

module irq_sync import csr_pkg::*; (
	input  wire logic i_clock,
	input  wire logic i_reset,

	// Asynchronous level inputs.
	input  wire logic i_timer,
	input  wire logic i_external,

	// Already in the clock domain.
	input  wire logic i_software,

	output irq_lines_t o_lines
);

	// Bit 1 is external, bit 0 is timer.
	logic [1:0] stage0;
	logic [1:0] stage1;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			stage0 <= 2'b0;
			stage1 <= 2'b0;
		end
		else begin
			stage0 <= {i_external, i_timer};
			stage1 <= stage0;
		end
	end

	assign o_lines = '{
		timer:    stage1[0],
		external: stage1[1],
		software: i_software
	};

endmodule

`default_nettype wire

//--- verilog/csr_access.sv
`timescale 1ns/100ps
`default_nettype none

module csr_access import csr_pkg::*; (
	input  wire logic        i_clock,
	input  wire logic        i_reset,

	input  wire csr_op_t     i_op,
	input  wire logic        i_op_valid,

	// CSR file access.
	output logic [11:0]      o_index,
	input  wire logic [31:0] i_rdata,
	output csr_write_t       o_write,

	output logic [31:0]      o_result,
	output logic             o_result_valid
);

	logic operand_zero;

	assign o_index      = i_op.index;
	assign operand_zero = (i_op.operand == 32'b0);

	// Read-modify-write on the old value.
	always_comb begin
		o_write.index  = i_op.index;
		o_write.strobe = 1'b0;
		o_write.data   = i_op.operand;
		case (i_op.kind)
			CSR_RW: begin
				o_write.strobe = i_op_valid;
			end
			CSR_RS: begin
				o_write.data   = i_rdata | i_op.operand;
				o_write.strobe = i_op_valid && !operand_zero;
			end
			CSR_RC: begin
				o_write.data   = i_rdata & ~i_op.operand;
				o_write.strobe = i_op_valid && !operand_zero;
			end
			default: ;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_result_valid <= 1'b0;
		else
			o_result_valid <= i_op_valid;
	end

	always_ff @(posedge i_clock) begin
		if (i_op_valid)
			o_result <= i_rdata;
	end

endmodule

`default_nettype wire

//--- verilog/csr_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_settings.svh"

module csr_file import csr_pkg::*; (
	input  wire logic        i_clock,
	input  wire logic        i_reset,

	// Read port.
	input  wire logic [11:0] i_index,
	output logic [31:0]      o_rdata,

	// Write port.
	input  wire csr_write_t  i_write,

	// Conditioned interrupt lines.
	input  wire irq_lines_t  i_irq,

	// Interrupt issue towards the trap sequencer.
	output logic             o_irq_pending,
	output logic [31:0]      o_irq_pc,
	output logic [31:0]      o_epc,
	output logic [31:0]      o_cause,
	input  wire logic        i_irq_dispatched,
	input  wire logic [31:0] i_irq_epc
);

	logic        mstatus_mie;
	irq_lines_t  mie_en;
	irq_lines_t  mip;
	logic [31:0] mtvec;
	logic [31:0] mepc;
	logic [31:0] mcause;

	// Source currently handed to the sequencer.
	irq_lines_t  issued;

	irq_lines_t  issue_bit;
	logic [31:0] issue_cause;
	logic        issue_any;

	assign o_epc   = mepc;
	assign o_cause = mcause;

	always_comb begin
		case (i_index)
			`CSR_MSTATUS:   o_rdata = {28'b0, mstatus_mie, 3'b0};
			`CSR_MIE:       o_rdata = {20'b0, mie_en.external, 3'b0, mie_en.timer, 3'b0,
				mie_en.software, 3'b0};
			`CSR_MTVEC:     o_rdata = mtvec;
			`CSR_MEPC:      o_rdata = mepc;
			`CSR_MCAUSE:    o_rdata = mcause;
			`CSR_MIP:       o_rdata = {20'b0, mip.external, 3'b0, mip.timer, 3'b0,
				mip.software, 3'b0};
			`CSR_MVENDORID: o_rdata = `CSR_VENDORID;
			`CSR_MARCHID:   o_rdata = `CSR_ARCHID;
			`CSR_MIMPID:    o_rdata = `CSR_IMPID;
			`CSR_MHARTID:   o_rdata = `CSR_HARTID;
			default:        o_rdata = 32'b0;
		endcase
	end

	// Highest-priority pending source.
	always_comb begin
		issue_bit   = '0;
		issue_cause = 32'b0;
		if (mip.timer) begin
			issue_bit.timer = 1'b1;
			issue_cause     = `CAUSE_TIMER;
		end
		else if (mip.external) begin
			issue_bit.external = 1'b1;
			issue_cause        = `CAUSE_EXTERNAL;
		end
		else if (mip.software) begin
			issue_bit.software = 1'b1;
			issue_cause        = `CAUSE_SOFTWARE;
		end
	end

	assign issue_any = mip.timer | mip.external | mip.software;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mstatus_mie   <= 1'b0;
			mie_en        <= '0;
			mip           <= '0;
			mtvec         <= 32'b0;
			mepc          <= 32'b0;
			mcause        <= 32'b0;
			issued        <= '0;
			o_irq_pending <= 1'b0;
		end
		else begin
			if (i_write.strobe) begin
				case (i_write.index)
					`CSR_MSTATUS: mstatus_mie <= i_write.data[3];
					`CSR_MIE: begin
						mie_en.external <= i_write.data[11];
						mie_en.timer    <= i_write.data[7];
						mie_en.software <= i_write.data[3];
					end
					`CSR_MTVEC:   mtvec <= i_write.data;
					`CSR_MEPC:    mepc <= i_write.data;
					default: ;
				endcase
			end

			// Latch enabled requests.
			if (mstatus_mie) begin
				if (i_irq.timer && mie_en.timer)
					mip.timer <= 1'b1;
				if (i_irq.external && mie_en.external)
					mip.external <= 1'b1;
				if (i_irq.software && mie_en.software)
					mip.software <= 1'b1;
			end

			if (!o_irq_pending && issue_any) begin
				o_irq_pending <= 1'b1;
				mcause        <= issue_cause;
				issued        <= issue_bit;
			end

			// Dispatch overrides both latching and an mepc write.
			if (i_irq_dispatched) begin
				mepc <= i_irq_epc;
				if (issued.timer)
					mip.timer <= 1'b0;
				if (issued.external)
					mip.external <= 1'b0;
				if (issued.software)
					mip.software <= 1'b0;
				o_irq_pending <= 1'b0;
				issued        <= '0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (!o_irq_pending && issue_any)
			o_irq_pc <= mtvec;
	end

endmodule

`default_nettype wire

//--- verilog/trap_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_settings.svh"

module trap_sequencer import csr_pkg::*; (
	input  wire logic        i_clock,
	input  wire logic        i_reset,

	input  wire logic        i_step,
	input  wire logic        i_mret,

	// Issue from the CSR file.
	input  wire logic        i_irq_pending,
	input  wire logic [31:0] i_irq_pc,
	input  wire logic [31:0] i_epc,
	input  wire logic [31:0] i_cause,
	output logic             o_irq_dispatched,
	output logic [31:0]      o_irq_epc,

	output logic [31:0]      o_pc,
	output trap_t            o_trap
);

	logic [31:0] pc;
	logic        trap_taken;
	logic [31:0] trap_cause;
	logic [31:0] trap_epc;
	logic [31:0] trap_target;

	// Take every issued interrupt on the cycle it appears.
	assign o_irq_dispatched = i_irq_pending;
	assign o_irq_epc        = pc;
	assign o_pc             = pc;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pc         <= `RESET_PC;
			trap_taken <= 1'b0;
		end
		else begin
			trap_taken <= o_irq_dispatched;
			if (o_irq_dispatched)
				pc <= i_irq_pc;
			else if (i_mret)
				pc <= i_epc;
			else if (i_step)
				pc <= pc + 32'd4;
		end
	end

	always_ff @(posedge i_clock) begin
		if (o_irq_dispatched) begin
			trap_cause  <= i_cause;
			trap_epc    <= pc;
			trap_target <= i_irq_pc;
		end
	end

	assign o_trap = '{taken: trap_taken, cause: trap_cause, epc: trap_epc, target: trap_target};

endmodule

`default_nettype wire

//--- verilog/csr_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module csr_subsystem import csr_pkg::*; (
	input  wire logic       i_clock,
	input  wire logic       i_reset,

	input  wire csr_op_t    i_op,
	input  wire logic       i_op_valid,

	input  wire logic       i_timer_irq,
	input  wire logic       i_external_irq,
	input  wire logic       i_ecall,

	input  wire logic       i_step,
	input  wire logic       i_mret,

	output logic [31:0]     o_result,
	output logic            o_result_valid,
	output logic [31:0]     o_pc,
	output trap_t           o_trap
);

	logic [11:0] csr_index;
	logic [31:0] csr_rdata;
	csr_write_t  csr_write;
	irq_lines_t  irq_lines;
	logic        irq_pending;
	logic [31:0] irq_pc;
	logic [31:0] epc;
	logic [31:0] cause;
	logic        irq_dispatched;
	logic [31:0] irq_epc;

	irq_sync irq_sync0 (
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_timer    (i_timer_irq),
		.i_external (i_external_irq),
		.i_software (i_ecall),
		.o_lines    (irq_lines)
	);

	csr_access csr_access0 (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_op           (i_op),
		.i_op_valid     (i_op_valid),
		.o_index        (csr_index),
		.i_rdata        (csr_rdata),
		.o_write        (csr_write),
		.o_result       (o_result),
		.o_result_valid (o_result_valid)
	);

	csr_file csr_file0 (
		.i_clock          (i_clock),
		.i_reset          (i_reset),
		.i_index          (csr_index),
		.o_rdata          (csr_rdata),
		.i_write          (csr_write),
		.i_irq            (irq_lines),
		.o_irq_pending    (irq_pending),
		.o_irq_pc         (irq_pc),
		.o_epc            (epc),
		.o_cause          (cause),
		.i_irq_dispatched (irq_dispatched),
		.i_irq_epc        (irq_epc)
	);

	trap_sequencer trap_sequencer0 (
		.i_clock          (i_clock),
		.i_reset          (i_reset),
		.i_step           (i_step),
		.i_mret           (i_mret),
		.i_irq_pending    (irq_pending),
		.i_irq_pc         (irq_pc),
		.i_epc            (epc),
		.i_cause          (cause),
		.o_irq_dispatched (irq_dispatched),
		.o_irq_epc        (irq_epc),
		.o_pc             (o_pc),
		.o_trap           (o_trap)
	);

endmodule

`default_nettype wire

//--- tests/csr_subsystem_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_settings.svh"

module csr_subsystem_tb import csr_pkg::*; ();

	logic        clock = 1'b0;
	logic        reset;
	csr_op_t     op;
	logic        op_valid;
	logic        timer_irq;
	logic        external_irq;
	logic        ecall;
	logic        step;
	logic        mret;
	logic [31:0] result;
	logic        result_valid;
	logic [31:0] pc;
	trap_t       trap;

	// Reference model state.
	logic        m_mstatus_mie;
	irq_lines_t  m_en;
	irq_lines_t  m_mip;
	irq_lines_t  m_issued;
	logic        m_pending;
	logic [31:0] m_mtvec;
	logic [31:0] m_mepc;
	logic [31:0] m_mcause;
	logic [31:0] m_irq_pc;
	logic [31:0] m_pc;
	logic [1:0]  m_sync0;
	logic [1:0]  m_sync1;
	logic        m_taken;
	logic [31:0] m_tcause;
	logic [31:0] m_tepc;
	logic [31:0] m_ttarget;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_start = 0;

	csr_subsystem dut0 (
		.i_clock        (clock),
		.i_reset        (reset),
		.i_op           (op),
		.i_op_valid     (op_valid),
		.i_timer_irq    (timer_irq),
		.i_external_irq (external_irq),
		.i_ecall        (ecall),
		.i_step         (step),
		.i_mret         (mret),
		.o_result       (result),
		.o_result_valid (result_valid),
		.o_pc           (pc),
		.o_trap         (trap)
	);

	always #5 clock = ~clock;

	// Bits sit at 11, 7 and 3 as in mie and mip.
	function automatic logic [31:0] irq_word(input irq_lines_t lines);
		logic [31:0] word;
		word     = 32'b0;
		word[11] = lines.external;
		word[7]  = lines.timer;
		word[3]  = lines.software;
		return word;
	endfunction

	function automatic logic [31:0] model_read(input logic [11:0] index);
		case (index)
			`CSR_MSTATUS:   return {28'b0, m_mstatus_mie, 3'b0};
			`CSR_MIE:       return irq_word(m_en);
			`CSR_MTVEC:     return m_mtvec;
			`CSR_MEPC:      return m_mepc;
			`CSR_MCAUSE:    return m_mcause;
			`CSR_MIP:       return irq_word(m_mip);
			`CSR_MVENDORID: return `CSR_VENDORID;
			`CSR_MARCHID:   return `CSR_ARCHID;
			`CSR_MIMPID:    return `CSR_IMPID;
			`CSR_MHARTID:   return `CSR_HARTID;
			default:        return 32'b0;
		endcase
	endfunction

	always @(posedge clock) begin : model_update
		logic [31:0] old_pc;
		logic [31:0] old_val;
		logic [31:0] wdata;
		logic        write;
		logic        dispatch;
		irq_lines_t  next_mip;
		if (reset) begin
			m_mstatus_mie = 1'b0;
			m_en          = '0;
			m_mip         = '0;
			m_issued      = '0;
			m_pending     = 1'b0;
			m_mtvec       = 32'b0;
			m_mepc        = 32'b0;
			m_mcause      = 32'b0;
			m_pc          = `RESET_PC;
			m_sync0       = 2'b0;
			m_sync1       = 2'b0;
			m_taken       = 1'b0;
		end
		else begin
			old_pc   = m_pc;
			old_val  = model_read(op.index);
			dispatch = m_pending;
			write    = op_valid && (op.kind == CSR_RW || op.operand != 32'b0);
			case (op.kind)
				CSR_RS:  wdata = old_val | op.operand;
				CSR_RC:  wdata = old_val & ~op.operand;
				default: wdata = op.operand;
			endcase
			m_taken = dispatch;
			if (dispatch) begin
				m_tcause  = m_mcause;
				m_tepc    = old_pc;
				m_ttarget = m_irq_pc;
				m_pc      = m_irq_pc;
			end
			else if (mret)
				m_pc = m_mepc;
			else if (step)
				m_pc = old_pc + 32'd4;
			next_mip = m_mip;
			if (m_mstatus_mie) begin
				if (m_sync1[0] && m_en.timer)
					next_mip.timer = 1'b1;
				if (m_sync1[1] && m_en.external)
					next_mip.external = 1'b1;
				if (ecall && m_en.software)
					next_mip.software = 1'b1;
			end
			// Timer first, then external, then software.
			if (!m_pending && m_mip != '0) begin
				m_pending = 1'b1;
				m_irq_pc  = m_mtvec;
				m_issued  = '0;
				if (m_mip.timer) begin
					m_issued.timer = 1'b1;
					m_mcause       = `CAUSE_TIMER;
				end
				else if (m_mip.external) begin
					m_issued.external = 1'b1;
					m_mcause          = `CAUSE_EXTERNAL;
				end
				else begin
					m_issued.software = 1'b1;
					m_mcause          = `CAUSE_SOFTWARE;
				end
			end
			if (write) begin
				case (op.index)
					`CSR_MSTATUS: m_mstatus_mie = wdata[3];
					`CSR_MIE: begin
						m_en = '{timer: wdata[7], external: wdata[11],
							software: wdata[3]};
					end
					`CSR_MTVEC:   m_mtvec = wdata;
					`CSR_MEPC:    m_mepc = wdata;
					default: ;
				endcase
			end
			if (dispatch) begin
				m_mepc    = old_pc;
				next_mip  = irq_lines_t'(next_mip & ~m_issued);
				m_pending = 1'b0;
				m_issued  = '0;
			end
			m_mip   = next_mip;
			m_sync1 = m_sync0;
			m_sync0 = {external_irq, timer_irq};
		end
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		assert (got === expected) else begin
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, expected);
			errors++;
		end
	endtask

	// pc and the trap report follow the model on every cycle.
	always @(negedge clock) begin
		if (!reset) begin
			check_value(pc, m_pc, "pc");
			check_value({31'b0, trap.taken}, {31'b0, m_taken}, "trap taken");
			if (m_taken) begin
				check_value(trap.cause, m_tcause, "trap cause");
				check_value(trap.epc, m_tepc, "trap epc");
				check_value(trap.target, m_ttarget, "trap target");
			end
		end
	end

	task automatic run_csr(input csr_op_e op_kind, input logic [11:0] op_index,
		input logic [31:0] op_operand, output logic [31:0] got);
		logic [31:0] expected;
		op       = '{kind: op_kind, index: op_index, operand: op_operand};
		op_valid = 1'b1;
		expected = model_read(op_index);
		@(posedge clock);
		@(negedge clock);
		op_valid = 1'b0;
		got      = result;
		check_value({31'b0, result_valid}, 32'd1, "result valid");
		check_value(result, expected, $sformatf("old value of CSR %h", op_index));
	endtask

	task automatic step_random(input int cycles);
		for (int n = 0; n < cycles; n++) begin
			step = $urandom % 2;
			@(negedge clock);
		end
		step = 1'b0;
	endtask

	task automatic wait_trap(input int limit, output logic seen);
		int count;
		count = 0;
		while (!trap.taken && count < limit) begin
			@(negedge clock);
			count++;
		end
		seen = trap.taken;
	endtask

	task automatic settle();
		int count;
		count = 0;
		while ((m_pending || m_mip != '0 || m_sync0 != 2'b0 || m_sync1 != 2'b0 || trap.taken)
			&& count < 50) begin
			@(negedge clock);
			count++;
		end
		assert (count < 50) else begin
			$display("Timeout: the interrupt logic did not go idle within 50 cycles");
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_start) begin
			$display("Test %s: passed", name);
		end
		else begin
			tests_failed++;
			$display("Test %s: %0d errors", name, errors - test_start);
		end
		test_start = errors;
	endtask

	initial begin : main
		logic [11:0] known_index [10];
		logic [31:0] reset_value [10];
		logic [11:0] unknown_index [4];
		logic [31:0] order_cause [3];
		logic [31:0] order_mip [3];
		logic [31:0] got;
		logic [31:0] vector;
		logic [31:0] epc;
		logic [31:0] operand;
		logic [11:0] index;
		logic        seen;
		int          src;
		int          sel;
		known_index   = '{`CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE, `CSR_MIP,
			`CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID, `CSR_MHARTID};
		reset_value   = '{32'b0, 32'b0, 32'b0, 32'b0, 32'b0, 32'b0,
			`CSR_VENDORID, `CSR_ARCHID, `CSR_IMPID, `CSR_HARTID};
		unknown_index = '{12'h000, 12'h340, 12'hC00, 12'hF15};
		order_cause   = '{`CAUSE_TIMER, `CAUSE_EXTERNAL, `CAUSE_SOFTWARE};
		order_mip     = '{32'h0000_0808, 32'h0000_0008, 32'h0};
		void'($urandom(27955));
		op           = '0;
		op_valid     = 1'b0;
		timer_irq    = 1'b0;
		external_irq = 1'b0;
		ecall        = 1'b0;
		step         = 1'b0;
		mret         = 1'b0;
		reset        = 1'b1;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		check_value(pc, `RESET_PC, "pc after reset");
		check_value({31'b0, result_valid}, 32'd0, "result valid after reset");
		for (int i = 0; i < 10; i++) begin
			run_csr(CSR_RS, known_index[i], 32'b0, got);
			check_value(got, reset_value[i], $sformatf("CSR %h after reset", known_index[i]));
		end
		for (int i = 0; i < 4; i++) begin
			run_csr(CSR_RS, unknown_index[i], 32'b0, got);
			check_value(got, 32'b0, $sformatf("unknown CSR %h", unknown_index[i]));
		end
		end_test("reset and ID reads");

		for (int n = 0; n < 200; n++) begin
			sel     = $urandom % 12;
			index   = (sel < 10) ? known_index[sel] : 12'($urandom);
			operand = ($urandom % 8 == 0) ? 32'b0 : $urandom;
			run_csr(csr_op_e'($urandom % 3), index, operand, got);
		end
		for (int i = 0; i < 10; i++)
			run_csr(CSR_RS, known_index[i], 32'b0, got);
		end_test("random CSR instructions");

		// Single source, 0 timer, 1 external, 2 software.
		src    = $urandom % 3;
		vector = $urandom & 32'hFFFF_FFFC;
		run_csr(CSR_RW, `CSR_MTVEC, vector, got);
		run_csr(CSR_RW, `CSR_MIE, (src == 0) ? 32'h80 : (src == 1) ? 32'h800 : 32'h8, got);
		run_csr(CSR_RW, `CSR_MSTATUS, 32'h8, got);
		step_random(5 + $urandom % 20);
		case (src)
			0: timer_irq = 1'b1;
			1: external_irq = 1'b1;
			default: begin
				ecall = 1'b1;
				@(negedge clock);
				ecall = 1'b0;
			end
		endcase
		wait_trap(20, seen);
		assert (seen) else begin
			$display("Timeout: no trap within 20 cycles of the single interrupt");
			errors++;
		end
		if (seen) begin
			check_value(trap.cause, order_cause[src], "single trap cause");
			check_value(trap.epc, m_tepc, "single trap epc");
			check_value(trap.target, vector, "single trap target");
			epc          = m_tepc;
			timer_irq    = 1'b0;
			external_irq = 1'b0;
			mret         = 1'b1;
			run_csr(CSR_RS, `CSR_MEPC, 32'b0, got);
			mret = 1'b0;
			check_value(got, epc, "mepc read back");
			check_value(pc, epc, "pc after MRET");
			run_csr(CSR_RS, `CSR_MCAUSE, 32'b0, got);
			check_value(got, order_cause[src], "mcause read back");
		end
		timer_irq    = 1'b0;
		external_irq = 1'b0;
		settle();
		run_csr(CSR_RW, `CSR_MSTATUS, 32'b0, got);
		end_test("single interrupt");

		// Timer not enabled in mie.
		run_csr(CSR_RW, `CSR_MIE, 32'h808, got);
		run_csr(CSR_RW, `CSR_MSTATUS, 32'h8, got);
		timer_irq = 1'b1;
		wait_trap(50, seen);
		assert (!seen) else begin
			$display("Unexpected trap from a timer interrupt that mie disables");
			errors++;
		end
		run_csr(CSR_RS, `CSR_MIP, 32'b0, got);
		check_value(got, 32'b0, "mip with timer masked");
		timer_irq = 1'b0;
		// Everything enabled but MIE clear.
		run_csr(CSR_RW, `CSR_MSTATUS, 32'b0, got);
		run_csr(CSR_RW, `CSR_MIE, 32'h888, got);
		timer_irq    = 1'b1;
		external_irq = 1'b1;
		ecall        = 1'b1;
		@(negedge clock);
		ecall = 1'b0;
		wait_trap(50, seen);
		assert (!seen) else begin
			$display("Unexpected trap while mstatus.MIE is clear");
			errors++;
		end
		run_csr(CSR_RS, `CSR_MIP, 32'b0, got);
		check_value(got, 32'b0, "mip with MIE clear");
		timer_irq    = 1'b0;
		external_irq = 1'b0;
		settle();
		end_test("masking");

		// All three bits latch at the same edge.
		run_csr(CSR_RW, `CSR_MTVEC, vector, got);
		run_csr(CSR_RW, `CSR_MSTATUS, 32'h8, got);
		timer_irq    = 1'b1;
		external_irq = 1'b1;
		@(negedge clock);
		timer_irq    = 1'b0;
		external_irq = 1'b0;
		@(negedge clock);
		ecall = 1'b1;
		@(negedge clock);
		ecall = 1'b0;
		for (int k = 0; k < 3; k++) begin
			wait_trap(20, seen);
			assert (seen) else begin
				$display("Timeout: trap %0d of the priority sequence did not arrive", k);
				errors++;
			end
			check_value(trap.cause, order_cause[k], $sformatf("cause of trap %0d", k));
			run_csr(CSR_RS, `CSR_MIP, 32'b0, got);
			check_value(got, order_mip[k], $sformatf("mip after trap %0d", k));
		end
		settle();
		run_csr(CSR_RW, `CSR_MSTATUS, 32'b0, got);
		end_test("priority");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end
		else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
verilog/csr_pkg.sv
verilog/irq_sync.sv
verilog/csr_access.sv
verilog/csr_file.sv
verilog/trap_sequencer.sv
verilog/csr_subsystem.sv
tests/csr_subsystem_tb.sv
